//--- src/rv_isa_pkg.sv
/*
 * RV32I definitions for the execution slice.
 * Holds opcode constants, field widths, the ALU operation encoding
 * and the decoded-instruction struct that the decoder hands to the
 * execution controller. Import into any module that touches them.
 */

package rv_isa_pkg;

  typedef logic [31:0] word_t;     // Data word and register value
  typedef logic [4:0]  reg_addr_t; // Register index
  typedef logic [6:0]  opcode_t;

  // Recognised major opcodes
  localparam opcode_t OPCODE_OP    = 7'b0110011;
  localparam opcode_t OPCODE_OPIMM = 7'b0010011;
  localparam opcode_t OPCODE_LUI   = 7'b0110111;
  localparam opcode_t OPCODE_LOAD  = 7'b0000011;
  localparam opcode_t OPCODE_STORE = 7'b0100011;

  localparam logic [2:0] FUNCT3_WORD = 3'b010; // LW / SW only

  // Encoded as {instr[30], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU_REG,
    CLS_ALU_IMM,
    CLS_LUI,
    CLS_LOAD,
    CLS_STORE,
    CLS_ILLEGAL
  } instr_class_e;

  typedef struct packed {
    instr_class_e cls;
    alu_op_e      alu_op;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        imm;     // Sign extended
    logic         wb;      // Register write wanted
    logic         use_imm; // Operand B is imm
  } decoded_instr_t;

endpackage

//--- src/bus_pkg.sv
/*
 * Bus side definitions.
 * APB address map of the core, data RAM size and the request and
 * response structs that pass between the arbiter and its two
 * requesters (host memory window and load-store path).
 */

package bus_pkg;

  import rv_isa_pkg::*;

  typedef logic [11:0] apb_addr_t; // APB byte address

  localparam apb_addr_t ADDR_INSTR    = 12'h000;
  localparam apb_addr_t ADDR_STATUS   = 12'h004;
  localparam apb_addr_t ADDR_REG_BASE = 12'h080; // 32 words
  localparam apb_addr_t ADDR_MEM_BASE = 12'h400;

  localparam int RAM_WORDS = 256;
  localparam int MEM_AW    = $clog2(RAM_WORDS);

  typedef logic [MEM_AW-1:0] mem_addr_t; // Word index

  typedef struct packed {
    logic      req;
    logic      we;
    mem_addr_t addr;
    word_t     wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;   // Same cycle as the RAM access
    word_t rdata; // Valid one cycle after gnt
  } mem_rsp_t;

endpackage

//--- src/instr_decoder.sv
/*
 * RV32I instruction decoder.
 * Turns the instruction register into a decoded_instr_t, registered
 * once, so the result is valid one cycle after the word changes.
 * Only OP, OP-IMM, LUI, LW and SW are legal here; anything else
 * comes out as CLS_ILLEGAL with no register write.
 */

`timescale 1ns/1ps

module instr_decoder import rv_isa_pkg::*; (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  word_t          instr_i,
  output decoded_instr_t decoded_o
);

  opcode_t        opcode;
  logic [2:0]     funct3;
  word_t          imm_i_type;
  word_t          imm_s_type;
  word_t          imm_u_type;
  decoded_instr_t dec_d;
  decoded_instr_t dec_q;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // Immediate formats
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    dec_d.cls     = CLS_ILLEGAL;
    dec_d.alu_op  = ALU_ADD;
    dec_d.rs1     = instr_i[19:15];
    dec_d.rs2     = instr_i[24:20];
    dec_d.rd      = instr_i[11:7];
    dec_d.imm     = '0;
    dec_d.wb      = 1'b0;
    dec_d.use_imm = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        // Bit 30 is only valid for SUB and SRA
        if (!instr_i[30] || funct3 == 3'b000 || funct3 == 3'b101) begin
          dec_d.cls    = CLS_ALU_REG;
          dec_d.alu_op = alu_op_e'({instr_i[30], funct3});
          dec_d.wb     = 1'b1;
        end
      end
      OPCODE_OPIMM: begin
        dec_d.cls     = CLS_ALU_IMM;
        dec_d.alu_op  = alu_op_e'({funct3 == 3'b101 && instr_i[30], funct3}); // SRAI
        dec_d.imm     = imm_i_type;
        dec_d.use_imm = 1'b1;
        dec_d.wb      = 1'b1;
      end
      OPCODE_LUI: begin
        dec_d.cls = CLS_LUI;
        dec_d.imm = imm_u_type;
        dec_d.wb  = 1'b1;
      end
      OPCODE_LOAD: begin
        if (funct3 == FUNCT3_WORD) begin
          dec_d.cls     = CLS_LOAD;
          dec_d.imm     = imm_i_type; // Address = rs1 + imm
          dec_d.use_imm = 1'b1;
          dec_d.wb      = 1'b1;
        end
      end
      OPCODE_STORE: begin
        if (funct3 == FUNCT3_WORD) begin
          dec_d.cls     = CLS_STORE;
          dec_d.imm     = imm_s_type;
          dec_d.use_imm = 1'b1;
        end
      end
      default: ; // Stays illegal
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign decoded_o = dec_q;

  // Stores and illegal words must never reach the register file
  a_no_wb_store_illegal: assert property (@(posedge clk_i) disable iff (!rstn_i)
    decoded_o.wb |-> !(decoded_o.cls inside {CLS_STORE, CLS_ILLEGAL}));

endmodule

//--- src/reg_file.sv
/*
 * Integer register file, 32 x 32 bit.
 * Two operand read ports, a third read port for host readback and
 * one synchronous write port. x0 always reads zero.
 */

`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rs3_i,
  output word_t     rd1_o,
  output word_t     rd2_o,
  output word_t     rd3_o,
  input  logic      we_i,
  input  reg_addr_t wa_i,
  input  word_t     wd_i
);

  word_t regs [32];

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wa_i != '0) begin // x0 writes dropped
      regs[wa_i] <= wd_i;
    end
  end

  assign rd1_o = regs[rs1_i];
  assign rd2_o = regs[rs2_i];
  assign rd3_o = regs[rs3_i]; // Host readback

endmodule

//--- src/alu.sv
/*
 * RV32I integer ALU, purely combinational.
 * The operation comes from the decoder as alu_op_e. Shifts use the
 * low five bits of operand B, as both register and immediate forms do.
 */

`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
  input  alu_op_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   y_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  y_o = a_i + b_i;
      ALU_SUB:  y_o = a_i - b_i;
      ALU_SLL:  y_o = a_i << shamt;
      ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: y_o = {31'b0, a_i < b_i};
      ALU_XOR:  y_o = a_i ^ b_i;
      ALU_SRL:  y_o = a_i >> shamt;
      ALU_SRA:  y_o = word_t'($signed(a_i) >>> shamt); // Keeps sign
      ALU_OR:   y_o = a_i | b_i;
      ALU_AND:  y_o = a_i & b_i;
      default:  y_o = '0;
    endcase
  end

endmodule

//--- src/exec_ctrl.sv
/*
 * Execution controller with the APB slave port.
 * A write to the INSTR address loads the instruction register and
 * starts the FSM: decode, execute, then an optional word load or store
 * through the arbiter. The same port reads status, registers and the
 * RAM window. pready_o, pslverr_o and prdata_o are registered.
 */

`timescale 1ns/1ps

module exec_ctrl import rv_isa_pkg::*, bus_pkg::*; (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  apb_addr_t      paddr_i,
  input  word_t          pwdata_i,
  output word_t          prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  input  decoded_instr_t decoded_i,
  output word_t          instr_o,
  output reg_addr_t      rf_ra1_o,
  output reg_addr_t      rf_ra2_o,
  output reg_addr_t      rf_ra3_o,
  input  word_t          rf_rd1_i,
  input  word_t          rf_rd2_i,
  input  word_t          rf_rd3_i,
  output logic           rf_we_o,
  output reg_addr_t      rf_wa_o,
  output word_t          rf_wd_o,
  output alu_op_e        alu_op_o,
  output word_t          alu_a_o,
  output word_t          alu_b_o,
  input  word_t          alu_y_i,
  output mem_req_t       host_req_o,
  input  mem_rsp_t       host_rsp_i,
  output mem_req_t       lsu_req_o,
  input  mem_rsp_t       lsu_rsp_i
);

  typedef enum logic [2:0] {IDLE, DECODE, EXECUTE, MEM_REQ, MEM_WAIT} state_e;

  state_e   state_q;
  word_t    ir_q;
  logic     illegal_q;
  mem_req_t lsu_req_q;
  logic     pready_q, pslverr_q, host_rd_pend_q;
  word_t    prdata_q;
  logic     acc_new, done;
  logic     hit_instr, hit_status, hit_reg, hit_mem, unmapped;
  logic     instr_wr, status_wr;
  word_t    rdata_mux;

  //////////////////////////////
  // APB address decode
  //////////////////////////////
  assign acc_new    = psel_i && penable_i && !pready_q; // Access phase not yet answered
  assign hit_instr  = paddr_i == ADDR_INSTR;
  assign hit_status = paddr_i == ADDR_STATUS;
  assign hit_reg    = paddr_i[11:7] == ADDR_REG_BASE[11:7];
  assign hit_mem    = paddr_i[11:10] == ADDR_MEM_BASE[11:10];
  assign unmapped   = !(hit_instr || hit_status || hit_reg || hit_mem);
  assign instr_wr   = acc_new && pwrite_i && hit_instr && state_q == IDLE;
  assign status_wr  = acc_new && pwrite_i && hit_status;

  // Host window request, held by APB until granted
  assign host_req_o.req   = acc_new && hit_mem && !host_rd_pend_q;
  assign host_req_o.we    = pwrite_i;
  assign host_req_o.addr  = paddr_i[MEM_AW+1:2];
  assign host_req_o.wdata = pwdata_i;

  always_comb begin
    done = 1'b1;
    if (hit_mem) begin
      done = pwrite_i ? host_rsp_i.gnt : host_rd_pend_q;
    end else if (hit_instr && pwrite_i) begin
      done = state_q == IDLE; // Stall while busy
    end
  end

  always_comb begin
    if (hit_mem)         rdata_mux = host_rsp_i.rdata;
    else if (hit_status) rdata_mux = {30'b0, illegal_q, state_q != IDLE};
    else if (hit_reg)    rdata_mux = rf_rd3_i;
    else if (hit_instr)  rdata_mux = ir_q;
    else                 rdata_mux = '0;
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pready_q       <= 1'b0;
      pslverr_q      <= 1'b0;
      host_rd_pend_q <= 1'b0;
    end else begin
      pready_q       <= acc_new && done;
      pslverr_q      <= acc_new && done && unmapped;
      host_rd_pend_q <= host_req_o.req && !pwrite_i && host_rsp_i.gnt;
    end
    if (acc_new && done && !pwrite_i) prdata_q <= rdata_mux;
  end

  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;
  assign prdata_o  = prdata_q;

  //////////////////////////////
  // Execution FSM
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q   <= IDLE;
      ir_q      <= '0;
      illegal_q <= 1'b0;
      lsu_req_q <= '0;
    end else begin
      if (instr_wr) ir_q <= pwdata_i;
      if (status_wr) illegal_q <= 1'b0; // A new illegal below still wins
      case (state_q)
        IDLE:    if (instr_wr) state_q <= DECODE;
        DECODE:  state_q <= EXECUTE; // Decoder output settles here
        EXECUTE: begin
          state_q <= IDLE;
          if (decoded_i.cls == CLS_LOAD || decoded_i.cls == CLS_STORE) begin
            lsu_req_q.req   <= 1'b1;
            lsu_req_q.we    <= decoded_i.cls == CLS_STORE;
            lsu_req_q.addr  <= alu_y_i[MEM_AW+1:2];
            lsu_req_q.wdata <= rf_rd2_i;
            state_q         <= MEM_REQ;
          end else if (decoded_i.cls == CLS_ILLEGAL) begin
            illegal_q <= 1'b1;
          end
        end
        MEM_REQ: begin
          if (lsu_rsp_i.gnt) begin
            lsu_req_q.req <= 1'b0;
            state_q       <= lsu_req_q.we ? IDLE : MEM_WAIT;
          end
        end
        MEM_WAIT: state_q <= IDLE; // Load data on the bus now
        default:  state_q <= IDLE;
      endcase
    end
  end

  assign instr_o   = ir_q;
  assign lsu_req_o = lsu_req_q;

  // Operands and write-back
  assign rf_ra1_o = decoded_i.rs1;
  assign rf_ra2_o = decoded_i.rs2;
  assign rf_ra3_o = paddr_i[6:2];
  assign alu_op_o = decoded_i.alu_op;
  assign alu_a_o  = rf_rd1_i;
  assign alu_b_o  = decoded_i.use_imm ? decoded_i.imm : rf_rd2_i;

  assign rf_we_o = (state_q == EXECUTE && decoded_i.wb && decoded_i.cls != CLS_LOAD)
                || state_q == MEM_WAIT;
  assign rf_wa_o = decoded_i.rd;
  assign rf_wd_o = state_q == MEM_WAIT     ? lsu_rsp_i.rdata :
                   decoded_i.cls == CLS_LUI ? decoded_i.imm  : alu_y_i;

  a_lsu_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    lsu_req_o.req && !lsu_rsp_i.gnt |=> $stable(lsu_req_o));

endmodule

//--- src/mem_arbiter.sv
/*
 * Fixed-priority arbiter in front of the data RAM.
 * The load-store path always wins over the host window. Grant is
 * given in the cycle the RAM is addressed; read data is returned one
 * cycle later to whichever side held the grant.
 */

`timescale 1ns/1ps

module mem_arbiter import rv_isa_pkg::*, bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  mem_req_t  host_req_i,
  input  mem_req_t  lsu_req_i,
  output mem_rsp_t  host_rsp_o,
  output mem_rsp_t  lsu_rsp_o,
  output logic      ram_we_o,
  output mem_addr_t ram_addr_o,
  output word_t     ram_wdata_o,
  input  word_t     ram_rdata_i
);

  logic gnt_lsu, gnt_host;
  logic last_lsu_q, last_host_q; // Grant owner one cycle back

  assign gnt_lsu  = lsu_req_i.req;
  assign gnt_host = host_req_i.req && !lsu_req_i.req;

  // RAM port mux
  assign ram_we_o    = gnt_lsu ? lsu_req_i.we    : gnt_host && host_req_i.we;
  assign ram_addr_o  = gnt_lsu ? lsu_req_i.addr  : host_req_i.addr;
  assign ram_wdata_o = gnt_lsu ? lsu_req_i.wdata : host_req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_lsu_q  <= 1'b0;
      last_host_q <= 1'b0;
    end else begin
      last_lsu_q  <= gnt_lsu;
      last_host_q <= gnt_host;
    end
  end

  assign lsu_rsp_o.gnt    = gnt_lsu;
  assign lsu_rsp_o.rdata  = last_lsu_q ? ram_rdata_i : '0;
  assign host_rsp_o.gnt   = gnt_host;
  assign host_rsp_o.rdata = last_host_q ? ram_rdata_i : '0;

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(host_rsp_o.gnt && lsu_rsp_o.gnt));

endmodule

//--- src/data_ram.sv
/*
 * Single-port data RAM, RAM_WORDS x 32 bit.
 * Write on the clock edge, registered read with one cycle latency.
 */

`timescale 1ns/1ps

module data_ram import rv_isa_pkg::*, bus_pkg::*; (
  input  logic      clk_i,
  input  logic      we_i,
  input  mem_addr_t addr_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  word_t mem [RAM_WORDS];
  word_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    rdata_q <= mem[addr_i]; // Old data on a write cycle
  end

  assign rdata_o = rdata_q;

endmodule

//--- src/core_top.sv
/*
 * Top of the RV32I execution slice.
 * Ties decoder, register file, ALU, execution controller, arbiter
 * and data RAM together. The only external port is the APB slave.
 */

`timescale 1ns/1ps

module core_top import rv_isa_pkg::*, bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  word_t     pwdata_i,
  output word_t     prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  word_t          instr;
  decoded_instr_t decoded;
  reg_addr_t      ra1, ra2, ra3, wa;
  word_t          rd1, rd2, rd3, wd;
  logic           rf_we;
  alu_op_e        alu_op;
  word_t          alu_a, alu_b, alu_y;
  mem_req_t       host_req, lsu_req;
  mem_rsp_t       host_rsp, lsu_rsp;
  logic           ram_we;
  mem_addr_t      ram_addr;
  word_t          ram_wdata, ram_rdata;

  instr_decoder u_decoder (
    .clk_i, .rstn_i, .instr_i(instr), .decoded_o(decoded)
  );

  reg_file u_rf (
    .clk_i, .rstn_i,
    .rs1_i(ra1), .rs2_i(ra2), .rs3_i(ra3),
    .rd1_o(rd1), .rd2_o(rd2), .rd3_o(rd3),
    .we_i(rf_we), .wa_i(wa), .wd_i(wd)
  );

  alu u_alu (.op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .y_o(alu_y));

  exec_ctrl u_ctrl (
    .clk_i, .rstn_i,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .decoded_i(decoded), .instr_o(instr),
    .rf_ra1_o(ra1), .rf_ra2_o(ra2), .rf_ra3_o(ra3),
    .rf_rd1_i(rd1), .rf_rd2_i(rd2), .rf_rd3_i(rd3),
    .rf_we_o(rf_we), .rf_wa_o(wa), .rf_wd_o(wd),
    .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_y_i(alu_y),
    .host_req_o(host_req), .host_rsp_i(host_rsp),
    .lsu_req_o(lsu_req), .lsu_rsp_i(lsu_rsp)
  );

  mem_arbiter u_arb (
    .clk_i, .rstn_i,
    .host_req_i(host_req), .lsu_req_i(lsu_req),
    .host_rsp_o(host_rsp), .lsu_rsp_o(lsu_rsp),
    .ram_we_o(ram_we), .ram_addr_o(ram_addr),
    .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
  );

  data_ram u_ram (
    .clk_i, .we_i(ram_we), .addr_i(ram_addr), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
  );

endmodule

//--- verification/core_tb.sv
/*
 * Testbench for the RV32I execution slice.
 * Sends instruction words and RAM traffic over APB, keeps its own
 * register and RAM model, and lets concurrent assertions compare each
 * checked read against that model. A cycle counter bounds the run.
 */

`timescale 1ns/1ps

module core_tb import rv_isa_pkg::*, bus_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  // Roughly 700 cycles of traffic with a wide margin on top
  localparam int MAX_CYCLES   = 4000;

  logic      clk_i;
  logic      rstn_i;
  logic      psel, penable, pwrite;
  apb_addr_t paddr;
  word_t     pwdata, prdata;
  logic      pready, pslverr;

  word_t     ref_regs [32];       // Register model
  word_t     ref_mem [RAM_WORDS]; // RAM model
  logic      chk_rd;              // Current read is compared
  word_t     exp_rdata;
  logic      exp_slverr;
  string     test_name;
  int        cycle_count = 0;
  word_t     lcg_state;

  core_top DUT (
    .clk_i, .rstn_i,
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Checkers
  //////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped");
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      abort_run("Timeout, the DUT stopped answering on APB");
    end
  end

  a_read_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
    psel && penable && pready && !pwrite && chk_rd |-> prdata == exp_rdata)
    else begin
      $display("Mismatch in %s: expected %h, actual %h", test_name, exp_rdata,
               $sampled(prdata));
      abort_run("Read data differs from the model");
    end

  a_read_err: assert property (@(posedge clk_i) disable iff (!rstn_i)
    psel && penable && pready && !pwrite && chk_rd |-> pslverr == exp_slverr)
    else begin
      $display("Mismatch in %s: expected %b, actual %b", test_name, exp_slverr,
               $sampled(pslverr));
      abort_run("Error response differs from the model");
    end

  a_write_ok: assert property (@(posedge clk_i) disable iff (!rstn_i)
    psel && penable && pready && pwrite |-> !pslverr)
    else abort_run("An APB write to a mapped address returned an error");

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // RV32I result rules by funct3 with alt selecting SUB and SRA
  function automatic word_t expected_result(input logic [2:0] f3, input logic alt,
                                            input word_t a, input word_t b);
    word_t y;
    case (f3)
      3'b000:  y = alt ? a - b : a + b;
      3'b001:  y = a << b[4:0];
      3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  y = (a < b) ? 32'd1 : 32'd0;
      3'b100:  y = a ^ b;
      3'b101:  y = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic mem_addr_t mem_index(input reg_addr_t rs1, input logic [11:0] imm);
    word_t addr;
    addr = ref_regs[rs1] + sext12(imm);
    return addr[9:2];
  endfunction

  // Caller is 1 ns past a rising edge, and so is the return
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                          output word_t rdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk_i);
    #1;
    penable = 1'b1;
    @(negedge clk_i);
    while (!pready) @(negedge clk_i);
    rdata = prdata;
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    chk_rd  = 1'b0;
  endtask

  task automatic write_word(input apb_addr_t addr, input word_t data);
    word_t unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic check_read(input apb_addr_t addr, input word_t expected, input logic err,
                            input string name);
    word_t rdata;
    test_name  = name;
    exp_rdata  = expected;
    exp_slverr = err;
    chk_rd     = 1'b1;
    apb_xfer(1'b0, addr, '0, rdata);
  endtask

  task automatic check_reg(input reg_addr_t idx, input string name);
    check_read(ADDR_REG_BASE + apb_addr_t'({idx, 2'b00}), ref_regs[idx], 1'b0, name);
  endtask

  task automatic check_mem(input mem_addr_t w, input string name);
    check_read(ADDR_MEM_BASE + apb_addr_t'({w, 2'b00}), ref_mem[w], 1'b0, name);
  endtask

  task automatic host_write(input mem_addr_t w, input word_t data);
    ref_mem[w] = data;
    write_word(ADDR_MEM_BASE + apb_addr_t'({w, 2'b00}), data);
  endtask

  // Polls status until busy falls
  task automatic wait_idle();
    word_t status;
    status = 32'h1;
    while (status[0]) apb_xfer(1'b0, ADDR_STATUS, '0, status);
  endtask

  task automatic issue(input word_t instr, input bit wait_done);
    write_word(ADDR_INSTR, instr);
    if (wait_done) wait_idle();
  endtask

  task automatic model_write_reg(input reg_addr_t rd, input word_t value);
    if (rd != 5'd0) ref_regs[rd] = value; // x0 stays zero
  endtask

  //////////////////////////////
  // Instruction tasks
  //////////////////////////////
  task automatic lui(input reg_addr_t rd, input logic [19:0] imm, input bit wait_done = 1'b1);
    issue({imm, rd, OPCODE_LUI}, wait_done);
    model_write_reg(rd, {imm, 12'b0});
  endtask

  task automatic op_imm(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                        input logic [11:0] imm, input bit wait_done = 1'b1);
    word_t result;
    result = expected_result(f3, 1'b0, ref_regs[rs1], sext12(imm));
    issue({imm, rs1, f3, rd, OPCODE_OPIMM}, wait_done);
    model_write_reg(rd, result);
  endtask

  task automatic op_reg(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                        input reg_addr_t rs1, input reg_addr_t rs2);
    word_t result;
    result = expected_result(f3, alt, ref_regs[rs1], ref_regs[rs2]);
    issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPCODE_OP}, 1'b1);
    model_write_reg(rd, result);
  endtask

  task automatic load_word(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm,
                           input bit wait_done = 1'b1);
    word_t loaded;
    loaded = ref_mem[mem_index(rs1, imm)];
    issue({imm, rs1, FUNCT3_WORD, rd, OPCODE_LOAD}, wait_done);
    model_write_reg(rd, loaded);
  endtask

  task automatic store_word(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm,
                            input bit wait_done = 1'b1);
    ref_mem[mem_index(rs1, imm)] = ref_regs[rs2];
    issue({imm[11:5], rs2, rs1, FUNCT3_WORD, imm[4:0], OPCODE_STORE}, wait_done);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    word_t      rnd;
    logic [2:0] f3;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    rstn_i     = 1'b0;
    chk_rd     = 1'b0;
    exp_rdata  = '0;
    exp_slverr = 1'b0;
    test_name  = "reset";
    lcg_state  = 32'd54;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++) ref_mem[i] = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;
    check_read(ADDR_STATUS, 32'h0, 1'b0, "reset");

    // OP-IMM and LUI with immediates of either sign
    for (int i = 1; i < 5; i++) begin
      rnd = next_random();
      lui(reg_addr_t'(i), rnd[31:12]);
      check_reg(reg_addr_t'(i), "opimm_lui");
    end
    for (int i = 0; i < 20; i++) begin
      rnd = next_random();
      f3  = (i % 3 == 0) ? 3'b000 : (i % 3 == 1) ? 3'b100 : 3'b010; // ADDI XORI SLTI
      op_imm(f3, rnd[14:10], rnd[9:5], rnd[31:20]);
      check_reg(rnd[14:10], "opimm_lui");
    end

    // Every ALU op on two random operand sets
    for (int set = 0; set < 2; set++) begin
      rnd = next_random();
      lui(5'd10, rnd[31:12]);
      op_imm(3'b000, 5'd10, 5'd10, rnd[11:0]);
      rnd = next_random();
      lui(5'd11, rnd[31:12]);
      op_imm(3'b000, 5'd11, 5'd11, rnd[11:0]);
      for (int k = 0; k < 16; k++) begin
        if (k < 9 || k == 13) begin
          op_reg(k[2:0], k[3], reg_addr_t'(12 + k), 5'd10, 5'd11);
          check_reg(reg_addr_t'(12 + k), "op_reg");
        end
      end
    end
    op_reg(3'b000, 1'b0, 5'd0, 5'd10, 5'd11);
    check_reg(5'd0, "op_reg_x0");

    // Host fills RAM and the core moves words both ways
    for (int w = 16; w < 20; w++) host_write(mem_addr_t'(w), next_random());
    for (int w = 16; w < 20; w++) check_mem(mem_addr_t'(w), "store_load");
    op_imm(3'b000, 5'd20, 5'd0, 12'd64); // Base at word 16
    load_word(5'd21, 5'd20, 12'd0);
    load_word(5'd22, 5'd20, 12'd12);
    check_reg(5'd21, "store_load");
    check_reg(5'd22, "store_load");
    store_word(5'd21, 5'd20, 12'd32);
    store_word(5'd10, 5'd20, 12'hffc);
    check_mem(8'd24, "store_load");
    check_mem(8'd15, "store_load");
    load_word(5'd25, 5'd20, 12'hffc);
    check_reg(5'd25, "store_load");

    // Illegal words leave no trace except the sticky flag
    issue({20'h00100, 5'd5, 7'b1101111}, 1'b1); // JAL
    check_read(ADDR_STATUS, 32'h2, 1'b0, "illegal");
    write_word(ADDR_STATUS, 32'h2);
    check_read(ADDR_STATUS, 32'h0, 1'b0, "illegal");
    issue({12'd0, 5'd20, 3'b000, 5'd6, OPCODE_LOAD}, 1'b1); // LB
    check_read(ADDR_STATUS, 32'h2, 1'b0, "illegal");
    for (int i = 0; i < 32; i++) check_reg(reg_addr_t'(i), "illegal");
    write_word(ADDR_STATUS, 32'h0);
    check_read(ADDR_STATUS, 32'h0, 1'b0, "illegal");

    // Host read lands while the SW still holds the RAM
    store_word(5'd21, 5'd20, 12'd56, 1'b0);
    check_mem(8'd30, "contention");
    wait_idle();
    // Second INSTR write stalls until the LW is done
    load_word(5'd23, 5'd20, 12'd56, 1'b0);
    op_imm(3'b000, 5'd24, 5'd23, 12'd1);
    check_reg(5'd23, "contention");
    check_reg(5'd24, "contention");

    check_read(12'h200, 32'h0, 1'b1, "unmapped");
    check_read(12'h008, 32'h0, 1'b1, "unmapped");

    @(posedge clk_i);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- compile.f
src/rv_isa_pkg.sv
src/bus_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/exec_ctrl.sv
src/mem_arbiter.sv
src/data_ram.sv
src/core_top.sv
verification/core_tb.sv

//--- run.sh
#!/bin/sh
# Build the execution slice testbench with Verilator, run it, check the log

verilator --binary --timing --assert --top-module core_tb -f compile.f -o Vcore_tb \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vcore_tb > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; } || \
  grep -q "Simulation completed successfully" sim.log || { echo "Result: no verdict"; exit 1; }
echo "Result: PASS"
